//--- adc_front.sv
module adc_front #(
  parameter int unsigned CHN = 2
)(
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  rp_pkg::raw_t    [CHN-1:0] adc_dat_i,
  input  rp_pkg::stream_t [CHN-1:0] loop_i,
  input  logic                      digital_loop_i,
  input  rp_pkg::cal_t    [CHN-1:0] cal_i,
  output rp_pkg::stream_t [CHN-1:0] acq_o
);

  // converter delivers a sample every cycle once out of reset
  logic raw_vld_q;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_vld_q <= 1'b0;
    end else begin
      raw_vld_q <= 1'b1;
    end
  end

  for (genvar i = 0; i < CHN; i++) begin : for_adc

    // raw converter word in two's complement
    rp_pkg::smp_t    raw_q;
    // calibration input after the loopback mux
    rp_pkg::stream_t cal_in;

    // input register
    always_ff @(posedge adc_clk) begin
      raw_q <= rp_pkg::smp_t'(rp_pkg::code_flip(adc_dat_i[i]));
    end

    // digital loopback
    // calibrated dac stream replaces the converter
    always_comb begin
      if (digital_loop_i) begin
        cal_in = loop_i[i];
      end else begin
        cal_in.vld = raw_vld_q;
        cal_in.dat = raw_q;
      end
    end

    lin_cal lin_cal_adc (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .sti_i   (cal_in),
      .cal_i   (cal_i[i]),
      .sto_o   (acq_o[i])
    );

  end

endmodule

//--- dac_back.sv
module dac_back #(
  parameter int unsigned CHN = 2
)(
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  rp_pkg::stream_t [CHN-1:0] gen_i,
  input  rp_pkg::cal_t    [CHN-1:0] cal_i,
  output rp_pkg::stream_t [CHN-1:0] dac_cal_o,
  output rp_pkg::raw_t    [CHN-1:0] dac_dat_o
);

  // converter code for a zero sample
  localparam rp_pkg::raw_t DAC_MID = rp_pkg::raw_t'(rp_pkg::code_flip('0));

  for (genvar i = 0; i < CHN; i++) begin : for_dac

    // output code register
    rp_pkg::raw_t dac_q;

    lin_cal lin_cal_dac (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .sti_i   (gen_i[i]),
      .cal_i   (cal_i[i]),
      .sto_o   (dac_cal_o[i])
    );

    // back to converter code
    // dac sits at midscale after reset
    // last code held while no valid sample
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        dac_q <= DAC_MID;
      end else if (dac_cal_o[i].vld) begin
        dac_q <= rp_pkg::raw_t'(rp_pkg::code_flip(dac_cal_o[i].dat));
      end
    end

    assign dac_dat_o[i] = dac_q;

  end

endmodule

//--- lin_cal.sv
module lin_cal (
  input  logic            adc_clk,
  input  logic            top_rst,
  input  rp_pkg::stream_t sti_i,
  input  rp_pkg::cal_t    cal_i,
  output rp_pkg::stream_t sto_o
);

  // output rails
  localparam int SMP_MAX = 2 ** (rp_pkg::SMP_W - 1) - 1;
  localparam int SMP_MIN = -(2 ** (rp_pkg::SMP_W - 1));
  localparam int PRD_W   = rp_pkg::SMP_W + rp_pkg::MUL_W;

  // full product and its shifted copy
  logic signed [PRD_W-1:0]          prod_w;
  logic signed [PRD_W-1:0]          prod_sh_w;
  // stage 1
  logic                             vld1_q;
  logic signed [rp_pkg::MUL_W-1:0]  mul1_q;
  // stage 2, one guard bit for the offset
  logic signed [rp_pkg::MUL_W:0]    sum_w;
  rp_pkg::smp_t                     sat_w;
  logic                             vld2_q;
  rp_pkg::smp_t                     dat2_q;

  // gain, fraction bits dropped
  assign prod_w    = $signed(sti_i.dat) * $signed(cal_i.mul);
  assign prod_sh_w = prod_w >>> rp_pkg::CAL_SHIFT;

  // offset then clamp
  assign sum_w = mul1_q + $signed(cal_i.sum);

  always_comb begin
    if (sum_w > SMP_MAX) begin
      sat_w = rp_pkg::smp_t'(SMP_MAX);
    end else if (sum_w < SMP_MIN) begin
      sat_w = rp_pkg::smp_t'(SMP_MIN);
    end else begin
      sat_w = rp_pkg::smp_t'(sum_w);
    end
  end

  // valid follows the data through both stages
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= sti_i.vld;
      vld2_q <= vld1_q;
    end
  end

  always_ff @(posedge adc_clk) begin
    mul1_q <= prod_sh_w[rp_pkg::MUL_W-1:0];
    dat2_q <= sat_w;
  end

  assign sto_o = '{vld: vld2_q, dat: dat2_q};

  // unity gain and zero offset pass the sample through unchanged
  assert property (@(posedge adc_clk) disable iff (top_rst)
    sto_o.vld && ($past(cal_i.mul, 2) == rp_pkg::MUL_ONE) && ($past(cal_i.sum) == '0)
    |-> sto_o.dat == $past(sti_i.dat, 2));

endmodule

//--- pdm_gen.sv
module pdm_gen #(
  parameter int unsigned PDM_CHN = 4
)(
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  logic [PDM_CHN-1:0] [7:0] lvl_i,
  output logic [PDM_CHN-1:0]       pdm_o
);

  // first order modulator
  // the accumulator carry is the output pulse
  logic [PDM_CHN-1:0] [7:0] acc_q;
  // next accumulator value with carry on top
  logic [PDM_CHN-1:0] [8:0] sum_w;

  always_comb begin
    for (int i = 0; i < PDM_CHN; i++) begin
      sum_w[i] = {1'b0, acc_q[i]} + {1'b0, lvl_i[i]};
    end
  end

  // level L gives L carries per 256 cycles
  // accumulator wraps back to its start
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < PDM_CHN; i++) begin
        acc_q[i] <= sum_w[i][7:0];
        pdm_o[i] <= sum_w[i][8];
      end
    end
  end

  // first cycle after release still quiet
  // a cleared accumulator cannot carry
  assert property (@(posedge adc_clk) $fell(top_rst) |=> pdm_o == '0);

endmodule

//--- rp_pkg.sv
package rp_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // converter sample width
  localparam int SMP_W = 14;
  // calibration gain width
  localparam int MUL_W = 16;
  // pdm level width
  localparam int PDM_W = 8;
  // gain fraction bits
  localparam int CAL_SHIFT = 14;

  // sample path types
  typedef logic signed [SMP_W-1:0] smp_t;
  typedef logic signed [MUL_W-1:0] mul_t;
  typedef logic signed [SMP_W-1:0] sum_t;
  typedef logic        [SMP_W-1:0] raw_t;
  typedef logic        [PDM_W-1:0] pdm_t;

  // unity gain after reset
  localparam mul_t MUL_ONE = mul_t'(1 << CAL_SHIFT);

  // sample stream, no ready since converters never stall
  typedef struct packed {
    logic vld;
    smp_t dat;
  } stream_t;

  // per channel gain and offset
  typedef struct packed {
    mul_t mul;
    sum_t sum;
  } cal_t;

  ////////////////////////////////////////
  // AXI4-Lite
  ////////////////////////////////////////

  localparam int AXI_AW = 12;
  localparam int AXI_DW = 32;

  typedef logic [AXI_AW-1:0]   axi_addr_t;
  typedef logic [AXI_DW-1:0]   axi_data_t;
  typedef logic [AXI_DW/8-1:0] axi_strb_t;
  typedef logic [1:0]          axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // master to slave
  typedef struct packed {
    logic      awvalid;
    axi_addr_t awaddr;
    logic      wvalid;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      bready;
    logic      arvalid;
    axi_addr_t araddr;
    logic      rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic      awready;
    logic      wready;
    logic      bvalid;
    axi_resp_t bresp;
    logic      arready;
    logic      rvalid;
    axi_data_t rdata;
    axi_resp_t rresp;
  } axil_rsp_t;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  // housekeeping
  localparam axi_addr_t ADDR_HK_LOOP = 12'h000;
  localparam axi_addr_t ADDR_HK_LED  = 12'h004;
  // calibration, channel i at +4*i
  localparam axi_addr_t ADDR_ADC_MUL = 12'h100;
  localparam axi_addr_t ADDR_ADC_SUM = 12'h108;
  localparam axi_addr_t ADDR_DAC_MUL = 12'h110;
  localparam axi_addr_t ADDR_DAC_SUM = 12'h118;
  // pdm levels, channel i at +4*i
  localparam axi_addr_t ADDR_PDM     = 12'h200;

  // converter code to two's complement and back
  // sign bit stays, the rest is inverted
  function automatic logic [SMP_W-1:0] code_flip(input logic [SMP_W-1:0] code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

endpackage

//--- rp_regs.sv
module rp_regs #(
  parameter int unsigned CHN     = 2,
  parameter int unsigned PDM_CHN = 4
)(
  input  logic                       adc_clk,
  input  logic                       top_rst,
  input  rp_pkg::axil_req_t          axil_req_i,
  output rp_pkg::axil_rsp_t          axil_rsp_o,
  output rp_pkg::cal_t [CHN-1:0]     adc_cal_o,
  output rp_pkg::cal_t [CHN-1:0]     dac_cal_o,
  output logic                       digital_loop_o,
  output rp_pkg::pdm_t [PDM_CHN-1:0] pdm_lvl_o,
  output logic [7:0]                 led_o
);

  // handshakes
  logic              wr_hs;
  logic              rd_hs;
  // address decode
  logic              wr_hit;
  logic              rd_hit;
  // response channels
  logic              bvalid_q;
  rp_pkg::axi_resp_t bresp_q;
  logic              rvalid_q;
  rp_pkg::axi_resp_t rresp_q;
  rp_pkg::axi_data_t rdata_q;
  rp_pkg::axi_data_t rdata_w;

  // channel register address
  function automatic rp_pkg::axi_addr_t chn_addr(input rp_pkg::axi_addr_t base, input int i);
    return base + rp_pkg::axi_addr_t'(4 * i);
  endfunction

  // any mapped register
  function automatic logic addr_hit(input rp_pkg::axi_addr_t a);
    logic hit;
    hit = (a == rp_pkg::ADDR_HK_LOOP) || (a == rp_pkg::ADDR_HK_LED);
    for (int i = 0; i < CHN; i++) begin
      hit |= (a == chn_addr(rp_pkg::ADDR_ADC_MUL, i));
      hit |= (a == chn_addr(rp_pkg::ADDR_ADC_SUM, i));
      hit |= (a == chn_addr(rp_pkg::ADDR_DAC_MUL, i));
      hit |= (a == chn_addr(rp_pkg::ADDR_DAC_SUM, i));
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      hit |= (a == chn_addr(rp_pkg::ADDR_PDM, i));
    end
    return hit;
  endfunction

  ////////////////////////////////////////
  // write channel
  ////////////////////////////////////////

  // address and data taken together, only with no response pending
  assign wr_hs  = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign wr_hit = addr_hit(axil_req_i.awaddr);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      bvalid_q <= 1'b0;
    end else if (wr_hs) begin
      bvalid_q <= 1'b1;
    end else if (axil_req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (wr_hs) begin
      bresp_q <= wr_hit ? rp_pkg::RESP_OKAY : rp_pkg::RESP_SLVERR;
    end
  end

  // configuration registers
  // strobes ignored, a write replaces the whole register
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      pdm_lvl_o      <= '0;
      for (int i = 0; i < CHN; i++) begin
        adc_cal_o[i].mul <= rp_pkg::MUL_ONE;
        adc_cal_o[i].sum <= '0;
        dac_cal_o[i].mul <= rp_pkg::MUL_ONE;
        dac_cal_o[i].sum <= '0;
      end
    end else if (wr_hs) begin
      if (axil_req_i.awaddr == rp_pkg::ADDR_HK_LOOP) digital_loop_o <= axil_req_i.wdata[0];
      if (axil_req_i.awaddr == rp_pkg::ADDR_HK_LED)  led_o <= axil_req_i.wdata[7:0];
      for (int i = 0; i < CHN; i++) begin
        if (axil_req_i.awaddr == chn_addr(rp_pkg::ADDR_ADC_MUL, i))
          adc_cal_o[i].mul <= axil_req_i.wdata[rp_pkg::MUL_W-1:0];
        if (axil_req_i.awaddr == chn_addr(rp_pkg::ADDR_ADC_SUM, i))
          adc_cal_o[i].sum <= axil_req_i.wdata[rp_pkg::SMP_W-1:0];
        if (axil_req_i.awaddr == chn_addr(rp_pkg::ADDR_DAC_MUL, i))
          dac_cal_o[i].mul <= axil_req_i.wdata[rp_pkg::MUL_W-1:0];
        if (axil_req_i.awaddr == chn_addr(rp_pkg::ADDR_DAC_SUM, i))
          dac_cal_o[i].sum <= axil_req_i.wdata[rp_pkg::SMP_W-1:0];
      end
      for (int i = 0; i < PDM_CHN; i++) begin
        if (axil_req_i.awaddr == chn_addr(rp_pkg::ADDR_PDM, i))
          pdm_lvl_o[i] <= axil_req_i.wdata[rp_pkg::PDM_W-1:0];
      end
    end
  end

  ////////////////////////////////////////
  // read channel
  ////////////////////////////////////////

  assign rd_hs  = axil_req_i.arvalid && !rvalid_q;
  assign rd_hit = addr_hit(axil_req_i.araddr);

  // read mux, zero extended, unmapped reads give 0
  always_comb begin
    rdata_w = '0;
    if (axil_req_i.araddr == rp_pkg::ADDR_HK_LOOP) rdata_w[0] = digital_loop_o;
    if (axil_req_i.araddr == rp_pkg::ADDR_HK_LED)  rdata_w[7:0] = led_o;
    for (int i = 0; i < CHN; i++) begin
      if (axil_req_i.araddr == chn_addr(rp_pkg::ADDR_ADC_MUL, i))
        rdata_w[rp_pkg::MUL_W-1:0] = adc_cal_o[i].mul;
      if (axil_req_i.araddr == chn_addr(rp_pkg::ADDR_ADC_SUM, i))
        rdata_w[rp_pkg::SMP_W-1:0] = adc_cal_o[i].sum;
      if (axil_req_i.araddr == chn_addr(rp_pkg::ADDR_DAC_MUL, i))
        rdata_w[rp_pkg::MUL_W-1:0] = dac_cal_o[i].mul;
      if (axil_req_i.araddr == chn_addr(rp_pkg::ADDR_DAC_SUM, i))
        rdata_w[rp_pkg::SMP_W-1:0] = dac_cal_o[i].sum;
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      if (axil_req_i.araddr == chn_addr(rp_pkg::ADDR_PDM, i))
        rdata_w[rp_pkg::PDM_W-1:0] = pdm_lvl_o[i];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rd_hs) begin
      rdata_q <= rdata_w;
      rresp_q <= rd_hit ? rp_pkg::RESP_OKAY : rp_pkg::RESP_SLVERR;
    end
  end

  // response bundle
  always_comb begin
    axil_rsp_o.awready = wr_hs;
    axil_rsp_o.wready  = wr_hs;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = !rvalid_q;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  // responses wait for the master unchanged
  assert property (@(posedge adc_clk) disable iff (top_rst)
    bvalid_q && !axil_req_i.bready |=> bvalid_q && $stable(bresp_q));
  assert property (@(posedge adc_clk) disable iff (top_rst)
    rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));
  // one outstanding response per channel
  assert property (@(posedge adc_clk) disable iff (top_rst) wr_hs |=> !wr_hs);
  assert property (@(posedge adc_clk) disable iff (top_rst) rd_hs |=> !rd_hs);

endmodule

//--- rp_top.sv
module rp_top #(
  parameter int unsigned CHN     = 2,
  parameter int unsigned PDM_CHN = 4
)(
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // register bus
  input  rp_pkg::axil_req_t             axil_req_i,
  output rp_pkg::axil_rsp_t             axil_rsp_o,
  // ADC
  input  rp_pkg::raw_t    [CHN-1:0]     adc_dat_i,
  output rp_pkg::stream_t [CHN-1:0]     acq_o,
  // DAC
  input  rp_pkg::stream_t [CHN-1:0]     gen_i,
  output rp_pkg::raw_t    [CHN-1:0]     dac_dat_o,
  // PDM
  output logic            [PDM_CHN-1:0] pdm_o,
  // LED
  output logic            [7:0]         led_o
);

////////////////////////////////////////
// local signals
////////////////////////////////////////

// calibration settings
rp_pkg::cal_t [CHN-1:0] adc_cal;
rp_pkg::cal_t [CHN-1:0] dac_cal;
// housekeeping
logic                   digital_loop;
// pdm levels
rp_pkg::pdm_t [PDM_CHN-1:0] pdm_lvl;
// calibrated dac stream, also the loopback source
rp_pkg::stream_t [CHN-1:0]  dac_str;

////////////////////////////////////////
// housekeeping and calibration regs
////////////////////////////////////////

rp_regs #(
  .CHN     (CHN),
  .PDM_CHN (PDM_CHN)
) regs (
  .adc_clk        (adc_clk),
  .top_rst        (top_rst),
  .axil_req_i     (axil_req_i),
  .axil_rsp_o     (axil_rsp_o),
  .adc_cal_o      (adc_cal),
  .dac_cal_o      (dac_cal),
  .digital_loop_o (digital_loop),
  .pdm_lvl_o      (pdm_lvl),
  .led_o          (led_o)
);

////////////////////////////////////////
// analog mixed signals (pdm)
////////////////////////////////////////

pdm_gen #(
  .PDM_CHN (PDM_CHN)
) pdm (
  .adc_clk (adc_clk),
  .top_rst (top_rst),
  .lvl_i   (pdm_lvl),
  .pdm_o   (pdm_o)
);

////////////////////////////////////////
// ADC IO
////////////////////////////////////////

adc_front #(
  .CHN (CHN)
) adc (
  .adc_clk        (adc_clk),
  .top_rst        (top_rst),
  .adc_dat_i      (adc_dat_i),
  .loop_i         (dac_str),
  .digital_loop_i (digital_loop),
  .cal_i          (adc_cal),
  .acq_o          (acq_o)
);

////////////////////////////////////////
// DAC IO
////////////////////////////////////////

dac_back #(
  .CHN (CHN)
) dac (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .gen_i     (gen_i),
  .cal_i     (dac_cal),
  .dac_cal_o (dac_str),
  .dac_dat_o (dac_dat_o)
);

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile the testbench with Verilator and run it
# the exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_top -f src.f -o tb_rp_top
./obj_dir/tb_rp_top

//--- src.f
rp_pkg.sv
lin_cal.sv
adc_front.sv
dac_back.sv
pdm_gen.sv
rp_regs.sv
rp_top.sv
tb_rp_top.sv

//--- tb_rp_top.sv
module tb_rp_top;

  localparam int CHN        = 2;
  localparam int PDM_CHN    = 4;
  localparam int CLK_PERIOD = 4;
  // test lengths
  localparam int REG_OPS    = 80;
  localparam int STREAM_LEN = 200;
  localparam int RUNS       = 4;
  localparam int PDM_ROUNDS = 3;
  // generous bound for one bus access with random ready stretches
  localparam int BUS_OP_MAX = 40;
  localparam int WATCHDOG_CYCLES = 10
    + (2 * (4 * CHN + PDM_CHN + 2) + REG_OPS) * BUS_OP_MAX
    + RUNS * (STREAM_LEN + 8 + (1 + 4 * CHN) * BUS_OP_MAX)
    + PDM_ROUNDS * (256 + PDM_CHN * BUS_OP_MAX) + 1000;

  // register map
  localparam logic [11:0] A_LOOP    = 12'h000;
  localparam logic [11:0] A_LED     = 12'h004;
  localparam logic [11:0] A_ADC_MUL = 12'h100;
  localparam logic [11:0] A_ADC_SUM = 12'h108;
  localparam logic [11:0] A_DAC_MUL = 12'h110;
  localparam logic [11:0] A_DAC_SUM = 12'h118;
  localparam logic [11:0] A_PDM     = 12'h200;
  localparam logic [1:0]  OKAY      = 2'd0;
  localparam logic [1:0]  SLVERR    = 2'd2;

  typedef rp_pkg::stream_t [CHN-1:0] acq_vec_t;
  typedef rp_pkg::raw_t    [CHN-1:0] dac_vec_t;

  logic                       adc_clk;
  logic                       top_rst;
  rp_pkg::axil_req_t          axil_req;
  rp_pkg::axil_rsp_t          axil_rsp;
  rp_pkg::raw_t    [CHN-1:0]  adc_dat;
  rp_pkg::stream_t [CHN-1:0]  acq;
  rp_pkg::stream_t [CHN-1:0]  gen;
  rp_pkg::raw_t    [CHN-1:0]  dac_dat;
  logic [PDM_CHN-1:0]         pdm;
  logic [7:0]                 led;

  // shadow registers, indexed by word address
  logic [31:0] shadow [0:1023];
  logic [11:0] mapped_q [$];
  // calibration as last written
  logic [15:0] adc_mul [CHN];
  logic [13:0] adc_sum [CHN];
  logic [15:0] dac_mul [CHN];
  logic [13:0] dac_sum [CHN];
  // dac code the model expects to be held
  rp_pkg::raw_t dac_last [CHN];

  rp_top #(
    .CHN     (CHN),
    .PDM_CHN (PDM_CHN)
  ) DUT (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .adc_dat_i  (adc_dat),
    .acq_o      (acq),
    .gen_i      (gen),
    .dac_dat_o  (dac_dat),
    .pdm_o      (pdm),
    .led_o      (led)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, the testbench did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // register width from the map, 0 when unmapped
  function automatic int reg_width(input logic [11:0] addr);
    if (addr == A_LOOP) return 1;
    if (addr == A_LED) return 8;
    for (int i = 0; i < CHN; i++) begin
      if (addr == A_ADC_MUL + 12'(4 * i) || addr == A_DAC_MUL + 12'(4 * i)) return 16;
      if (addr == A_ADC_SUM + 12'(4 * i) || addr == A_DAC_SUM + 12'(4 * i)) return 14;
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      if (addr == A_PDM + 12'(4 * i)) return 8;
    end
    return 0;
  endfunction

  // converter code, sign kept and magnitude bits inverted
  function automatic logic [13:0] invert_code(input logic [13:0] c);
    return {c[13], ~c[12:0]};
  endfunction

  // gain with 14 fraction bits, offset, clamp to 14 bit signed
  function automatic int apply_cal(input int x, input logic [15:0] mul, input logic [13:0] off);
    int p;
    p = (x * int'($signed(mul))) >>> 14;
    p = p + int'($signed(off));
    if (p > 8191) begin
      p = 8191;
    end else if (p < -8192) begin
      p = -8192;
    end
    return p;
  endfunction

  // half near unity, half anything
  function automatic logic [15:0] rand_gain();
    if ($urandom_range(0, 1) == 0) begin
      return 16'(16384 + $urandom_range(0, 4096) - 2048);
    end
    return 16'($urandom);
  endfunction

  function automatic logic [13:0] rand_offset();
    if ($urandom_range(0, 1) == 0) begin
      return 14'($urandom_range(0, 512) - 256);
    end
    return 14'($urandom);
  endfunction

  // unaligned neighbours of real registers or anywhere in the space
  function automatic logic [11:0] random_unmapped();
    logic [11:0] a;
    a = mapped_q[$urandom_range(0, mapped_q.size() - 1)] + 12'($urandom_range(1, 3));
    while (reg_width(a) != 0) begin
      a = 12'($urandom);
    end
    return a;
  endfunction

  task automatic init_shadow();
    for (int a = 0; a < 4096; a += 4) begin
      if (reg_width(12'(a)) > 0) begin
        mapped_q.push_back(12'(a));
        shadow[a / 4] = 32'd0;
      end
    end
    // unity gain out of reset
    for (int i = 0; i < CHN; i++) begin
      shadow[(A_ADC_MUL + 12'(4 * i)) >> 2] = 32'd16384;
      shadow[(A_DAC_MUL + 12'(4 * i)) >> 2] = 32'd16384;
    end
  endtask

  ////////////////////////////////////////
  // checks and bus master
  ////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_idle();
    check("bvalid", 32'd0, 32'(axil_rsp.bvalid));
    check("rvalid", 32'd0, 32'(axil_rsp.rvalid));
    for (int i = 0; i < CHN; i++) begin
      check("acq_o.vld", 32'd0, 32'(acq[i].vld));
    end
    check("led_o", 32'd0, 32'(led));
    check("pdm_o", 32'd0, 32'(pdm));
  endtask

  // one access, response checked every cycle while ready stays low
  task automatic bus_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            input logic [1:0] exp_resp, input logic [31:0] exp_rdata);
    logic rdy;
    logic done;
    axil_req.awvalid = wr;
    axil_req.wvalid  = wr;
    axil_req.awaddr  = addr;
    axil_req.wdata   = wdata;
    axil_req.wstrb   = 4'hf;
    axil_req.arvalid = !wr;
    axil_req.araddr  = addr;
    // ready settles within the low phase
    #(CLK_PERIOD / 4);
    check("awready", 32'(wr), 32'(axil_rsp.awready));
    check("wready", 32'(wr), 32'(axil_rsp.wready));
    check("arready", 32'd1, 32'(axil_rsp.arready));
    @(negedge adc_clk);
    while (!(wr ? axil_rsp.bvalid : axil_rsp.rvalid)) begin
      @(negedge adc_clk);
    end
    // ready drops while a response is pending
    check("awready", 32'd0, 32'(axil_rsp.awready));
    check("wready", 32'd0, 32'(axil_rsp.wready));
    check("arready", 32'(wr), 32'(axil_rsp.arready));
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.arvalid = 1'b0;
    done = 1'b0;
    while (!done) begin
      if (wr) begin
        check("bvalid", 32'd1, 32'(axil_rsp.bvalid));
        check("bresp", 32'(exp_resp), 32'(axil_rsp.bresp));
      end else begin
        check("rvalid", 32'd1, 32'(axil_rsp.rvalid));
        check("rresp", 32'(exp_resp), 32'(axil_rsp.rresp));
        check("rdata", exp_rdata, axil_rsp.rdata);
      end
      rdy = 1'($urandom_range(0, 1));
      axil_req.bready = wr && rdy;
      axil_req.rready = !wr && rdy;
      @(negedge adc_clk);
      done = rdy;
    end
    axil_req.bready = 1'b0;
    axil_req.rready = 1'b0;
    check("bvalid", 32'd0, 32'(axil_rsp.bvalid));
    check("rvalid", 32'd0, 32'(axil_rsp.rvalid));
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
    int w;
    w = reg_width(addr);
    bus_access(1'b1, addr, data, (w > 0) ? OKAY : SLVERR, 32'd0);
    if (w > 0) begin
      shadow[addr[11:2]] = data & ((32'd1 << w) - 32'd1);
    end
  endtask

  task automatic reg_read(input logic [11:0] addr);
    int w;
    w = reg_width(addr);
    bus_access(1'b0, addr, 32'd0, (w > 0) ? OKAY : SLVERR,
               (w > 0) ? shadow[addr[11:2]] : 32'd0);
  endtask

  ////////////////////////////////////////
  // data path tests
  ////////////////////////////////////////

  task automatic configure_paths(input logic loop);
    reg_write(A_LOOP, {31'd0, loop});
    for (int i = 0; i < CHN; i++) begin
      adc_mul[i] = rand_gain();
      adc_sum[i] = rand_offset();
      dac_mul[i] = rand_gain();
      dac_sum[i] = rand_offset();
      reg_write(A_ADC_MUL + 12'(4 * i), {16'd0, adc_mul[i]});
      reg_write(A_ADC_SUM + 12'(4 * i), {18'd0, adc_sum[i]});
      reg_write(A_DAC_MUL + 12'(4 * i), {16'd0, dac_mul[i]});
      reg_write(A_DAC_SUM + 12'(4 * i), {18'd0, dac_sum[i]});
    end
  endtask

  // random adc and gen samples every cycle, both outputs checked
  task automatic run_streams(input logic loop, input int len);
    acq_vec_t acq_exp_q [$];
    dac_vec_t dac_exp_q [$];
    acq_vec_t acq_exp;
    dac_vec_t dac_exp;
    int       acq_lat;
    int       dac_val;
    // loopback adds the dac calibration stages
    acq_lat = loop ? 4 : 3;
    for (int t = 0; t < len + acq_lat; t++) begin
      @(negedge adc_clk);
      if (t >= acq_lat) begin
        acq_exp = acq_exp_q.pop_front();
        for (int i = 0; i < CHN; i++) begin
          check("acq_o.vld", 32'(acq_exp[i].vld), 32'(acq[i].vld));
          if (acq_exp[i].vld) begin
            check("acq_o.dat", 32'(acq_exp[i].dat), 32'(acq[i].dat));
          end
        end
      end
      if (t >= 3 && dac_exp_q.size() > 0) begin
        dac_exp = dac_exp_q.pop_front();
        for (int i = 0; i < CHN; i++) begin
          check("dac_dat_o", 32'(dac_exp[i]), 32'(dac_dat[i]));
        end
      end
      for (int i = 0; i < CHN; i++) begin
        if (t < len) begin
          adc_dat[i]  = rp_pkg::raw_t'($urandom);
          // first sample valid so the held dac code is known
          gen[i].vld  = (t == 0) ? 1'b1 : 1'($urandom_range(0, 1));
          gen[i].dat  = rp_pkg::smp_t'($urandom);
          dac_val     = apply_cal(int'(gen[i].dat), dac_mul[i], dac_sum[i]);
          if (gen[i].vld) begin
            dac_last[i] = invert_code(14'(dac_val));
          end
          dac_exp[i] = dac_last[i];
          if (loop) begin
            acq_exp[i].vld = gen[i].vld;
            acq_exp[i].dat = rp_pkg::smp_t'(apply_cal(dac_val, adc_mul[i], adc_sum[i]));
          end else begin
            acq_exp[i].vld = 1'b1;
            acq_exp[i].dat = rp_pkg::smp_t'(apply_cal(int'($signed(invert_code(adc_dat[i]))),
                                                      adc_mul[i], adc_sum[i]));
          end
        end else begin
          gen[i].vld = 1'b0;
        end
      end
      if (t < len) begin
        acq_exp_q.push_back(acq_exp);
        dac_exp_q.push_back(dac_exp);
      end
    end
  endtask

  // L ones per 256 cycles at constant level L
  task automatic pdm_density(input int round);
    logic [7:0] lvl [PDM_CHN];
    int         ones [PDM_CHN];
    for (int i = 0; i < PDM_CHN; i++) begin
      lvl[i]  = 8'($urandom);
      ones[i] = 0;
    end
    // both ends of the range once
    if (round == 0) begin
      lvl[0] = 8'd0;
      lvl[1] = 8'hff;
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      reg_write(A_PDM + 12'(4 * i), {24'd0, lvl[i]});
    end
    repeat (256) begin
      @(negedge adc_clk);
      for (int i = 0; i < PDM_CHN; i++) begin
        ones[i] += int'(pdm[i]);
      end
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      check("pdm_o ones", 32'(lvl[i]), 32'(ones[i]));
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : main
    int          kind;
    logic [11:0] addr;
    void'($urandom(32'h4a3573dd));
    top_rst  = 1'b1;
    axil_req = '0;
    adc_dat  = '0;
    gen      = '0;
    init_shadow();
    // outputs quiet during reset and right after it
    repeat (5) begin
      @(negedge adc_clk);
      check_idle();
    end
    top_rst = 1'b0;
    @(negedge adc_clk);
    check_idle();
    // reset values
    foreach (mapped_q[k]) begin
      reg_read(mapped_q[k]);
    end
    // random register traffic, a third of it unmapped
    for (int n = 0; n < REG_OPS; n++) begin
      kind = $urandom_range(0, 5);
      addr = (kind >= 4) ? random_unmapped()
                         : mapped_q[$urandom_range(0, mapped_q.size() - 1)];
      if (kind % 2 == 1) begin
        reg_write(addr, $urandom);
      end else begin
        reg_read(addr);
      end
    end
    // unmapped writes left everything alone
    foreach (mapped_q[k]) begin
      reg_read(mapped_q[k]);
    end
    check("led_o", shadow[A_LED >> 2], 32'(led));
    // adc and dac paths, then loopback, twice each
    for (int r = 0; r < RUNS; r++) begin
      configure_paths(r % 2 == 1);
      run_streams(r % 2 == 1, STREAM_LEN);
    end
    for (int r = 0; r < PDM_ROUNDS; r++) begin
      pdm_density(r);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
